// ==== hdl/cpuPkg.sv ====
// Micro CPU instruction set
`default_nettype none

package cpuPkg;

   // the register file has four byte-wide registers
   localparam int RegCount = 4;
   localparam int RegIndexWidth = 2;

   // ************************************************************************
   // opcodes, held in the upper nibble of every instruction byte
   // ************************************************************************

   typedef enum logic [3:0] {
      NOP, LDI, ADD, SUB, AND, XOR, MOV, ADDI,
      LD, ST, JMP, JZ, OUT, HALT
   } opcodeT;

   // register form, used by all opcodes except ADDI
   typedef struct packed {
      opcodeT opcode;
      logic [RegIndexWidth-1:0] dst;
      logic [RegIndexWidth-1:0] src;
   } regFormT;

   // short form carries a 4-bit immediate, ADDI only
   typedef struct packed {
      opcodeT opcode;
      logic [3:0] immediate;
   } shortFormT;

   // one instruction byte seen through either form
   typedef union packed {
      regFormT regForm;
      shortFormT shortForm;
   } instructionT;

   // fetch and dispatch sequencer states
   localparam logic [2:0] StateIdle = 3'd0;
   localparam logic [2:0] StateFetch = 3'd1;
   localparam logic [2:0] StateFetchOperand = 3'd2;
   localparam logic [2:0] StateDispatch = 3'd3;
   localparam logic [2:0] StateMemAccess = 3'd4;
   localparam logic [2:0] StateHalt = 3'd5;

endpackage

`default_nettype wire

// ==== hdl/executeUnit.sv ====
// Register file and ALU
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
   input  logic clock,
   input  logic resetN,
   input  logic dispatch,
   input  cpuPkg::opcodeT op,
   input  logic [cpuPkg::RegIndexWidth-1:0] dst,
   input  logic [cpuPkg::RegIndexWidth-1:0] src,
   input  logic [memPkg::DataWidth-1:0] immediate,
   input  logic writeBack,
   input  logic [cpuPkg::RegIndexWidth-1:0] writeIndex,
   input  logic [memPkg::DataWidth-1:0] writeValue,
   output logic resultValid,
   output logic [memPkg::DataWidth-1:0] resultData,
   output logic [cpuPkg::RegIndexWidth-1:0] resultDst,
   output logic writeEnable,
   output logic opIsOut,
   output logic [memPkg::AddressWidth-1:0] memAddress,
   output logic [memPkg::DataWidth-1:0] storeData
);
   import cpuPkg::*;
   import memPkg::*;

   logic [DataWidth-1:0] registers [RegCount];
   logic [DataWidth-1:0] srcValue;
   logic [DataWidth-1:0] dstValue;
   logic [DataWidth-1:0] aluResult;
   logic [RegIndexWidth-1:0] aluTarget;
   logic aluWrite;

   // registers change only through the result stage
   always_ff @(posedge clock) begin
      if (writeBack) registers[writeIndex] <= writeValue;
   end

   assign srcValue = registers[src];
   assign dstValue = registers[dst];

   // ************************************************************************
   // ALU
   // ************************************************************************

   always_comb begin
      aluResult = srcValue;
      aluTarget = dst;
      aluWrite = 1'b1;
      case (op)
         LDI:  aluResult = immediate;
         ADD:  aluResult = dstValue + srcValue;
         SUB:  aluResult = dstValue - srcValue;
         AND:  aluResult = dstValue & srcValue;
         XOR:  aluResult = dstValue ^ srcValue;
         MOV:  aluResult = srcValue;
         ADDI: begin
            // short form has no register field, the target is always r0
            aluResult = registers[0] + immediate;
            aluTarget = '0;
         end
         // LD writes later from memory, OUT passes the source value on
         default: aluWrite = 1'b0;
      endcase
   end

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         resultValid <= 1'b0;
         writeEnable <= 1'b0;
         opIsOut <= 1'b0;
      end else begin
         resultValid <= dispatch;
         writeEnable <= dispatch && aluWrite;
         opIsOut <= dispatch && (op == OUT);
      end
   end

   // results stay stable until the next dispatch, which a load relies on
   always_ff @(posedge clock) begin
      if (dispatch) begin
         resultData <= aluResult;
         resultDst <= aluTarget;
         memAddress <= srcValue;
         storeData <= dstValue;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/instructionDecode.sv ====
// Fetch and decode sequencer
`timescale 1ns/1ps
`default_nettype none

module instructionDecode (
   input  logic clock,
   input  logic resetN,
   input  logic start,
   input  logic busy,
   input  logic [memPkg::DataWidth-1:0] readData,
   input  logic zeroFlag,
   input  logic resultValid,
   input  logic [memPkg::AddressWidth-1:0] memAddress,
   input  logic [memPkg::DataWidth-1:0] storeData,
   output logic vma,
   output logic readWrite,
   output logic [memPkg::AddressWidth-1:0] address,
   output logic [memPkg::DataWidth-1:0] writeData,
   output logic dispatch,
   output cpuPkg::opcodeT op,
   output logic [cpuPkg::RegIndexWidth-1:0] dst,
   output logic [cpuPkg::RegIndexWidth-1:0] src,
   output logic [memPkg::DataWidth-1:0] immediate,
   output logic loadDone,
   output logic halted
);
   import cpuPkg::*;
   import memPkg::*;

   logic [2:0] state;
   logic [AddressWidth-1:0] pc;
   logic pending;
   logic capture;
   logic hasOperand;
   logic [DataWidth-1:0] operand;
   instructionT instruction;
   instructionT fetched;

   // pending marks an issued request whose busy phase has not ended
   assign fetched = readData;
   assign hasOperand = fetched.regForm.opcode inside {LDI, JMP, JZ};
   assign capture = pending && busy && (state inside {StateFetch, StateFetchOperand});

   // ************************************************************************
   // memory requests
   // ************************************************************************

   // data accesses start once the execute unit has the address ready
   assign vma = !pending && !busy
      && ((state inside {StateFetch, StateFetchOperand})
      || (state == StateMemAccess && resultValid));
   assign readWrite = (state != StateMemAccess) || (op == LD);
   assign address = (state == StateMemAccess) ? memAddress : pc;
   assign writeData = storeData;
   assign loadDone = (state == StateMemAccess) && pending && !busy && (op == LD);

   // instruction fields as seen by the execute unit
   assign dispatch = (state == StateDispatch);
   assign op = instruction.regForm.opcode;
   assign dst = instruction.regForm.dst;
   assign src = instruction.regForm.src;
   assign immediate = (op == ADDI) ? DataWidth'(instruction.shortForm.immediate) : operand;
   assign halted = (state == StateHalt);

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         state <= StateIdle;
         pc <= '0;
         pending <= 1'b0;
      end else begin
         if (vma) begin
            pending <= 1'b1;
         end
         case (state)
            StateIdle: if (start) state <= StateFetch;
            StateFetch: begin
               if (capture) begin
                  pending <= 1'b0;
                  pc <= pc + 1'b1;
                  state <= hasOperand ? StateFetchOperand : StateDispatch;
               end
            end
            StateFetchOperand: begin
               if (capture) begin
                  pending <= 1'b0;
                  pc <= pc + 1'b1;
                  state <= StateDispatch;
               end
            end
            StateDispatch: begin
               // jumps are resolved here and never reach memory
               if (op inside {LD, ST}) begin
                  state <= StateMemAccess;
               end else if (op == HALT) begin
                  state <= StateHalt;
               end else begin
                  state <= StateFetch;
                  if (op == JMP || (op == JZ && zeroFlag)) pc <= operand;
               end
            end
            StateMemAccess: begin
               // a store holds here through the whole write busy time
               if (pending && !busy) begin
                  pending <= 1'b0;
                  state <= StateFetch;
               end
            end
            default: state <= StateHalt;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (capture && state == StateFetch) instruction <= fetched;
      if (capture && state == StateFetchOperand) operand <= readData;
   end

   // every captured opcode is dispatched once before the next capture
   oneDispatchPerFetch: assert property (
      @(posedge clock) disable iff (!resetN)
      (capture && state == StateFetch) |=> !(capture && state == StateFetch) until dispatch);

   noDoubleDispatch: assert property (
      @(posedge clock) disable iff (!resetN)
      dispatch |=> !dispatch until (capture && state == StateFetch));

endmodule

`default_nettype wire

// ==== hdl/memPkg.sv ====
// Program memory parameters
`default_nettype none

package memPkg;

   // byte-wide memory with an 8-bit address
   localparam int AddressWidth = 8;
   localparam int DataWidth = 8;
   localparam int MemoryDepth = 256;

   // a write keeps busy high this many cycles, a read keeps it one cycle
   localparam int WriteBusyCycles = 3;

   // the busy counter must hold the longest access
   localparam int BusyCountWidth = $clog2(WriteBusyCycles + 1);

endpackage

`default_nettype wire

// ==== hdl/microCpu.sv ====
// Micro CPU top level
`timescale 1ns/1ps
`default_nettype none

module microCpu (
   input  logic clock,
   input  logic resetN,
   input  logic start,
   input  logic loadEnable,
   input  logic [memPkg::AddressWidth-1:0] loadAddress,
   input  logic [memPkg::DataWidth-1:0] loadData,
   output logic outValid,
   output logic [memPkg::DataWidth-1:0] outData,
   output logic halted
);
   import cpuPkg::*;
   import memPkg::*;

   // ************************************************************************
   // memory bus
   // ************************************************************************
   logic vma;
   logic readWrite;
   logic busy;
   logic [AddressWidth-1:0] address;
   logic [DataWidth-1:0] writeData;
   logic [DataWidth-1:0] readData;

   // dispatch from the sequencer to the execute unit
   logic dispatch;
   opcodeT op;
   logic [RegIndexWidth-1:0] dst;
   logic [RegIndexWidth-1:0] src;
   logic [DataWidth-1:0] immediate;

   // results, memory operands and write-back
   logic resultValid;
   logic [DataWidth-1:0] resultData;
   logic [RegIndexWidth-1:0] resultDst;
   logic writeEnable;
   logic opIsOut;
   logic [AddressWidth-1:0] memAddress;
   logic [DataWidth-1:0] storeData;
   logic loadDone;
   logic writeBack;
   logic [RegIndexWidth-1:0] writeIndex;
   logic [DataWidth-1:0] writeValue;
   logic zeroFlag;

   programMemory i_programMemory (
      .clock, .resetN, .vma, .readWrite, .address, .writeData,
      .loadEnable, .loadAddress, .loadData, .busy, .readData
   );

   instructionDecode i_instructionDecode (
      .clock, .resetN, .start, .busy, .readData, .zeroFlag, .resultValid,
      .memAddress, .storeData, .vma, .readWrite, .address, .writeData,
      .dispatch, .op, .dst, .src, .immediate, .loadDone, .halted
   );

   executeUnit i_executeUnit (
      .clock, .resetN, .dispatch, .op, .dst, .src, .immediate,
      .writeBack, .writeIndex, .writeValue, .resultValid, .resultData,
      .resultDst, .writeEnable, .opIsOut, .memAddress, .storeData
   );

   // the LD data path is the memory read bus
   resultWriteback i_resultWriteback (
      .clock, .resetN, .resultValid, .resultData, .resultDst, .writeEnable,
      .loadDone, .loadData(readData), .opIsOut, .writeBack, .writeIndex,
      .writeValue, .zeroFlag, .outValid, .outData
   );

endmodule

`default_nettype wire

// ==== hdl/programMemory.sv ====
// Program and data memory
`timescale 1ns/1ps
`default_nettype none

module programMemory (
   input  logic clock,
   input  logic resetN,
   input  logic vma,
   input  logic readWrite,
   input  logic [memPkg::AddressWidth-1:0] address,
   input  logic [memPkg::DataWidth-1:0] writeData,
   input  logic loadEnable,
   input  logic [memPkg::AddressWidth-1:0] loadAddress,
   input  logic [memPkg::DataWidth-1:0] loadData,
   output logic busy,
   output logic [memPkg::DataWidth-1:0] readData
);
   import memPkg::*;

   logic [DataWidth-1:0] memory [MemoryDepth];
   logic [BusyCountWidth-1:0] busyCount;

   // busy stays high while the counter runs down to zero
   assign busy = (busyCount != '0);

   // a request loads the counter on the cycle vma is sampled, so busy
   // rises one cycle after the request
   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         busyCount <= '0;
      end else if (vma) begin
         busyCount <= readWrite ? BusyCountWidth'(1) : BusyCountWidth'(WriteBusyCycles);
      end else if (busy) begin
         busyCount <= busyCount - 1'b1;
      end
   end

   // ************************************************************************
   // storage array
   // ************************************************************************

   // the load port fills the array before start, requests write it later
   always_ff @(posedge clock) begin
      if (loadEnable) begin
         memory[loadAddress] <= loadData;
      end else if (vma && !readWrite) begin
         memory[address] <= writeData;
      end
   end

   // read data is latched at the request and stays until the next read
   always_ff @(posedge clock) begin
      if (vma && readWrite) begin
         readData <= memory[address];
      end
   end

   // the sequencer must wait for a previous access to finish
   noRequestWhileBusy: assert property (
      @(posedge clock) disable iff (!resetN) vma |-> !busy);

   // the load port is only used while the CPU is idle
   noLoadDuringAccess: assert property (
      @(posedge clock) disable iff (!resetN) !(loadEnable && vma));

endmodule

`default_nettype wire

// ==== hdl/resultWriteback.sv ====
// Result write-back and output port
`timescale 1ns/1ps
`default_nettype none

module resultWriteback (
   input  logic clock,
   input  logic resetN,
   input  logic resultValid,
   input  logic [memPkg::DataWidth-1:0] resultData,
   input  logic [cpuPkg::RegIndexWidth-1:0] resultDst,
   input  logic writeEnable,
   input  logic loadDone,
   input  logic [memPkg::DataWidth-1:0] loadData,
   input  logic opIsOut,
   output logic writeBack,
   output logic [cpuPkg::RegIndexWidth-1:0] writeIndex,
   output logic [memPkg::DataWidth-1:0] writeValue,
   output logic zeroFlag,
   output logic outValid,
   output logic [memPkg::DataWidth-1:0] outData
);

   // load data reaches the register named by the LD that is still held
   // in resultDst, no other result can arrive while it is pending
   assign writeBack = (resultValid && writeEnable) || loadDone;
   assign writeIndex = resultDst;
   assign writeValue = loadDone ? loadData : resultData;

   // zero flag follows register results, loads leave it alone
   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         zeroFlag <= 1'b0;
         outValid <= 1'b0;
      end else begin
         if (resultValid && writeEnable) zeroFlag <= (resultData == '0);
         outValid <= resultValid && opIsOut;
      end
   end

   always_ff @(posedge clock) begin
      if (resultValid && opIsOut) outData <= resultData;
   end

   // a returning load and a register result never share the write port
   singleWriteSource: assert property (
      @(posedge clock) disable iff (!resetN) !(loadDone && resultValid && writeEnable));

endmodule

`default_nettype wire

// ==== tests/microCpuTb.sv ====
// Micro CPU testbench
`timescale 1ns/1ps
`default_nettype none

module microCpuTb;
   import cpuPkg::*;
   import memPkg::*;

   localparam int ResetCycles = 10;
   localparam int TailCycles = 8;
   localparam int NumPrograms = 4;
   localparam int InstructionsPerProgram = 16;
   localparam int TimeoutCycles = 64 * InstructionsPerProgram * NumPrograms;
   localparam int ModelStepLimit = 512;

   logic clock;
   logic resetN;
   logic start;
   logic loadEnable;
   logic [AddressWidth-1:0] loadAddress;
   logic [DataWidth-1:0] loadData;
   logic outValid;
   logic [DataWidth-1:0] outData;
   logic halted;

   logic running;
   logic [31:0] lfsrState = 32'ha082246f;
   logic [DataWidth-1:0] image [$];
   logic [DataWidth-1:0] expected [$];
   int mismatchCount = 0;
   int otherErrors = 0;
   int outputsChecked = 0;
   int programsRun = 0;
   int cycleCount = 0;

   microCpu i_microCpu (
      .clock, .resetN, .start, .loadEnable, .loadAddress, .loadData,
      .outValid, .outData, .halted
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per random bit
   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   task automatic drawBits(input int count, output logic [7:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsrState = lfsrNext(lfsrState);
         value = {value[6:0], lfsrState[0]};
      end
   endtask

   // ************************************************************************
   // program encoding
   // ************************************************************************

   // register form is opcode, destination, source
   task automatic putRegForm(input opcodeT op, input logic [1:0] d, input logic [1:0] s);
      image.push_back({op, d, s});
   endtask

   // LDI, JMP and JZ carry their byte right after the opcode
   task automatic appendTwoByte(input opcodeT op, input logic [1:0] d, input logic [7:0] value);
      image.push_back({op, d, 2'd0});
      image.push_back(value);
   endtask

   task automatic addShortForm(input logic [3:0] immediate);
      image.push_back({ADDI, immediate});
   endtask

   // ************************************************************************
   // instruction set model
   // ************************************************************************

   // walks the loaded image and queues every byte that OUT must produce
   task automatic predictOutputs();
      logic [7:0] memory [256];
      logic [7:0] regs [4];
      logic [7:0] instr;
      logic [7:0] operand;
      logic [7:0] value;
      logic [7:0] pc;
      logic [3:0] opc;
      logic [1:0] d;
      logic [1:0] s;
      logic zero;
      logic halt;
      int steps;
      expected.delete();
      for (int i = 0; i < image.size(); i++) memory[i] = image[i];
      pc = '0;
      zero = 1'b0;
      halt = 1'b0;
      steps = 0;
      while (!halt && steps < ModelStepLimit) begin
         instr = memory[pc];
         operand = memory[pc + 8'd1];
         opc = instr[7:4];
         d = instr[3:2];
         s = instr[1:0];
         pc = pc + 8'd1;
         if (opc inside {LDI, JMP, JZ}) pc = pc + 8'd1;
         value = regs[s];
         case (opc)
            LDI: value = operand;
            ADD: value = regs[d] + regs[s];
            SUB: value = regs[d] - regs[s];
            AND: value = regs[d] & regs[s];
            XOR: value = regs[d] ^ regs[s];
            ADDI: begin
               // short form always adds to r0
               d = 2'd0;
               value = regs[0] + {4'h0, instr[3:0]};
            end
            LD: regs[d] = memory[regs[s]];
            ST: memory[regs[s]] = regs[d];
            JMP: pc = operand;
            JZ: if (zero) pc = operand;
            OUT: expected.push_back(regs[s]);
            HALT: halt = 1'b1;
            default: ;
         endcase
         // register results set the zero flag, a load does not
         if (opc inside {LDI, ADD, SUB, AND, XOR, MOV, ADDI}) begin
            regs[d] = value;
            zero = (value == 8'd0);
         end
         steps++;
      end
      assert (halt) else begin
         otherErrors++;
         $display("model did not reach HALT within %0d steps", ModelStepLimit);
      end
   endtask

   // ************************************************************************
   // test programs
   // ************************************************************************

   task automatic arithmeticProgram();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] c;
      drawBits(8, a);
      drawBits(8, b);
      drawBits(8, c);
      image.delete();
      appendTwoByte(LDI, 2'd0, a);
      appendTwoByte(LDI, 2'd1, b);
      appendTwoByte(LDI, 2'd2, c);
      putRegForm(MOV, 2'd3, 2'd0);
      putRegForm(ADD, 2'd3, 2'd1);
      putRegForm(OUT, 2'd0, 2'd3);
      putRegForm(SUB, 2'd3, 2'd2);
      putRegForm(OUT, 2'd0, 2'd3);
      putRegForm(AND, 2'd0, 2'd1);
      putRegForm(OUT, 2'd0, 2'd0);
      putRegForm(XOR, 2'd1, 2'd2);
      putRegForm(OUT, 2'd0, 2'd1);
      putRegForm(MOV, 2'd2, 2'd0);
      putRegForm(OUT, 2'd0, 2'd2);
      putRegForm(HALT, 2'd0, 2'd0);
   endtask

   // r0 starts near the top so that the sum wraps past 8'hff
   task automatic addImmediateProgram();
      logic [7:0] low;
      logic [7:0] imm;
      logic [7:0] other;
      drawBits(3, low);
      drawBits(3, imm);
      drawBits(8, other);
      image.delete();
      appendTwoByte(LDI, 2'd0, 8'hf8 | low);
      appendTwoByte(LDI, 2'd1, other);
      addShortForm(4'h8 | imm[3:0]);
      putRegForm(OUT, 2'd0, 2'd0);
      addShortForm(imm[3:0]);
      putRegForm(OUT, 2'd0, 2'd0);
      putRegForm(OUT, 2'd0, 2'd1);
      putRegForm(HALT, 2'd0, 2'd0);
   endtask

   // data lives at the top of memory, well above the program bytes
   task automatic storeLoadProgram();
      logic [7:0] where;
      logic [7:0] data;
      drawBits(4, where);
      drawBits(8, data);
      image.delete();
      appendTwoByte(LDI, 2'd0, 8'hf0 | where);
      appendTwoByte(LDI, 2'd1, data);
      putRegForm(ST, 2'd1, 2'd0);
      appendTwoByte(LDI, 2'd1, ~data);
      putRegForm(LD, 2'd2, 2'd0);
      putRegForm(OUT, 2'd0, 2'd2);
      putRegForm(ST, 2'd1, 2'd0);
      putRegForm(LD, 2'd3, 2'd0);
      putRegForm(OUT, 2'd0, 2'd3);
      putRegForm(HALT, 2'd0, 2'd0);
   endtask

   // outputs r1 from N down to 1, JZ leaves the loop once r1 is zero
   task automatic countdownProgram();
      logic [7:0] count;
      logic [7:0] loopStart;
      drawBits(3, count);
      image.delete();
      appendTwoByte(LDI, 2'd1, count + 8'd1);
      appendTwoByte(LDI, 2'd2, 8'd1);
      loopStart = 8'(image.size());
      putRegForm(OUT, 2'd0, 2'd1);
      putRegForm(SUB, 2'd1, 2'd2);
      appendTwoByte(JZ, 2'd0, loopStart + 8'd6);
      appendTwoByte(JMP, 2'd0, loopStart);
      putRegForm(HALT, 2'd0, 2'd0);
   endtask

   // reset, load while idle, start and wait for halted
   task automatic runProgram();
      @(posedge clock);
      #1;
      running = 1'b0;
      resetN = 1'b0;
      repeat (ResetCycles) @(posedge clock);
      #1;
      resetN = 1'b1;
      for (int i = 0; i < image.size(); i++) begin
         loadEnable = 1'b1;
         loadAddress = AddressWidth'(i);
         loadData = image[i];
         @(posedge clock);
         #1;
      end
      loadEnable = 1'b0;
      predictOutputs();
      start = 1'b1;
      running = 1'b1;
      @(posedge clock);
      #1;
      start = 1'b0;
      @(negedge clock);
      while (!halted) @(negedge clock);
      // extra cycles would expose a strobe after the halt
      repeat (TailCycles) @(negedge clock);
      assert (expected.size() == 0) else begin
         otherErrors++;
         $display("program %0d halted with %0d expected output bytes never seen",
            programsRun, expected.size());
      end
      programsRun++;
   endtask

   // outputs are registered in the DUT, so the falling edge sees them settled
   always @(negedge clock) begin
      if (!running) begin
         assert (!outValid && !halted) else begin
            otherErrors++;
            $display("output strobe or halted seen before start at %0t", $time);
         end
      end
      assert (!(halted && outValid)) else begin
         otherErrors++;
         $display("output strobe seen after the CPU halted at %0t", $time);
      end
      if (outValid) begin
         outputsChecked++;
         assert (expected.size() != 0) else begin
            otherErrors++;
            $display("unexpected output byte %02h at %0t", outData, $time);
         end
         if (expected.size() != 0) begin
            assert (outData == expected[0]) else begin
               mismatchCount++;
               $display("MISMATCH at %0t: output byte %02h, expected %02h",
                  $time, outData, expected[0]);
            end
            void'(expected.pop_front());
         end
      end
   end

   // watchdog for a CPU that never halts
   initial begin
      while (cycleCount < TimeoutCycles) begin
         @(posedge clock);
         cycleCount++;
      end
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      resetN = 1'b0;
      start = 1'b0;
      loadEnable = 1'b0;
      loadAddress = '0;
      loadData = '0;
      running = 1'b0;
      arithmeticProgram();
      runProgram();
      addImmediateProgram();
      runProgram();
      storeLoadProgram();
      runProgram();
      countdownProgram();
      runProgram();
      $display("programs %0d, outputs checked %0d, mismatches %0d, other errors %0d",
         programsRun, outputsChecked, mismatchCount, otherErrors);
      if (mismatchCount == 0 && otherErrors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/cpuPkg.sv
hdl/memPkg.sv
hdl/programMemory.sv
hdl/instructionDecode.sv
hdl/executeUnit.sv
hdl/resultWriteback.sv
hdl/microCpu.sv
tests/microCpuTb.sv
